// File: conv_line.f
+incdir+common
common/conv_line_pkg.sv
source/weight_buffer.sv
source/line_window_buffer.sv
kcpe_array/kernel_channel_pe.sv
kcpe_array/kcpe_array.sv
source/psum_reducer.sv
source/conv_line_engine.sv
bench/conv_line_engine_props.sv
bench/conv_line_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the conv_line testbench with Verilator, then scan the log

rm -rf obj_dir sim.log

{ verilator --binary --timing --assert -Wno-fatal \
      -f conv_line.f --top-module conv_line_engine_tb \
      -Mdir obj_dir -o conv_line_sim \
  && ./obj_dir/conv_line_sim; } > sim.log 2>&1 \
  || echo "CHECKS FAILED" >> sim.log

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; } || { echo "Simulation passed"; exit 0; }

// File: bench/conv_line_engine_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_line_config.svh"

module conv_line_engine_tb;

    localparam int data_w    = `CONV_DATA_WIDTH;
    localparam int num_ch    = `CONV_NUM_CHANNEL;
    localparam int num_k     = `CONV_NUM_KERNEL;
    localparam int kern_w    = `CONV_KERNEL_WIDTH;
    localparam int psum_w    = `CONV_PSUM_WIDTH;
    localparam int max_len   = 64;
    localparam int num_tests = 6;

    typedef struct {
        string name;
        int    len;
        int    n_psum;
        bit    gaps;
        bit    rnd_ready;
        bit    extreme;
    } test_entry_t;

    logic                         clk;
    logic                         rst;
    conv_line_pkg::weight_beat_t  i_weight;
    logic                         i_weight_valid;
    logic                         o_weight_ready;
    conv_line_pkg::pixel_t        i_pixel;
    logic                         i_pixel_valid;
    logic                         o_pixel_ready;
    conv_line_pkg::pos_t          i_line_len;
    conv_line_pkg::psum_vec_t     o_psum;
    logic                         o_psum_valid;
    logic                         o_psum_last;
    logic                         i_psum_ready;

    test_entry_t                  tests [num_tests];
    string                        cur_test;
    conv_line_pkg::weight_beat_t  wbeat [kern_w];
    conv_line_pkg::pixel_t        pix [max_len];
    int                           gap [max_len];
    conv_line_pkg::psum_vec_t     exp_q [$];
    logic [31:0]                  data_rng = 32'd2;
    logic [31:0]                  ready_rng = 32'd2;
    int                           cycle_cnt = 0;
    int                           cycle_limit = 0;

    conv_line_engine i_conv_line_engine (
        .clk            (clk),
        .rst            (rst),
        .i_weight       (i_weight),
        .i_weight_valid (i_weight_valid),
        .o_weight_ready (o_weight_ready),
        .i_pixel        (i_pixel),
        .i_pixel_valid  (i_pixel_valid),
        .o_pixel_ready  (o_pixel_ready),
        .i_line_len     (i_line_len),
        .o_psum         (o_psum),
        .o_psum_valid   (o_psum_valid),
        .o_psum_last    (o_psum_last),
        .i_psum_ready   (i_psum_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Random source and failure handling

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int random_below(input int n);
        data_rng = xorshift(data_rng);
        return int'(data_rng[15:0]) % n;
    endfunction

    // Extreme mode picks only +127, -127 and -128
    function automatic conv_line_pkg::data_t random_element(input bit extreme);
        int pick;
        pick = random_below(256);
        if (!extreme) begin
            return conv_line_pkg::data_t'(pick);
        end
        case (pick % 3)
            0: return 8'h7f;
            1: return 8'h81;
            default: return 8'h80;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_psum(input string what, input conv_line_pkg::psum_vec_t expected,
                              input conv_line_pkg::psum_vec_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED test %s %s expected %h actual %h",
                                cur_test, what, expected, actual));
        end
    endtask

    task automatic check_last(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED test %s %s expected %b actual %b",
                                cur_test, what, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Line data and reference model

    task automatic prepare_line(input test_entry_t te);
        int                       acc;
        logic signed [data_w-1:0] px;
        logic signed [data_w-1:0] wt;
        conv_line_pkg::psum_vec_t expected;

        for (int p = 0; p < kern_w; p++) begin
            for (int e = 0; e < num_k * num_ch; e++) begin
                wbeat[p][e*data_w +: data_w] = random_element(te.extreme);
            end
        end
        for (int i = 0; i < te.len; i++) begin
            for (int c = 0; c < num_ch; c++) begin
                pix[i][c*data_w +: data_w] = random_element(te.extreme);
            end
            gap[i] = te.gaps ? random_below(3) : 0;
        end
        // Window ending at pixel k pairs its oldest pixel with beat 0
        for (int k = kern_w - 1; k < te.len; k++) begin
            for (int kn = 0; kn < num_k; kn++) begin
                acc = 0;
                for (int p = 0; p < kern_w; p++) begin
                    for (int c = 0; c < num_ch; c++) begin
                        px  = pix[k - kern_w + 1 + p][c*data_w +: data_w];
                        wt  = wbeat[p][(kn*num_ch + c)*data_w +: data_w];
                        acc = acc + px * wt;
                    end
                end
                expected[kn*psum_w +: psum_w] = acc[psum_w-1:0];
            end
            exp_q.push_back(expected);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stream drivers and output monitor

    task automatic load_weights();
        for (int b = 0; b < kern_w; b++) begin
            @(posedge clk);
            i_weight       <= wbeat[b];
            i_weight_valid <= 1'b1;
            @(negedge clk);
            check_last("pixel_ready during weight load", 1'b0, o_pixel_ready);
            while (!o_weight_ready) begin
                @(negedge clk);
                check_last("pixel_ready during weight load", 1'b0, o_pixel_ready);
            end
        end
        @(posedge clk);
        i_weight_valid <= 1'b0;
    endtask

    task automatic drive_pixels(input int len);
        for (int i = 0; i < len; i++) begin
            repeat (gap[i]) begin
                @(posedge clk);
                i_pixel_valid <= 1'b0;
            end
            @(posedge clk);
            i_pixel       <= pix[i];
            i_pixel_valid <= 1'b1;
            @(negedge clk);
            while (!o_pixel_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        i_pixel_valid <= 1'b0;
    endtask

    task automatic collect_psums(input int count, input bit rnd_ready);
        int   got;
        logic exp_last;

        got = 0;
        while (got < count) begin
            @(posedge clk);
            ready_rng = xorshift(ready_rng);
            i_psum_ready <= rnd_ready ? ready_rng[7] : 1'b1;
            @(negedge clk);
            if (o_psum_valid && i_psum_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("psum arrived with no expected value left");
                end
                exp_last = (got == count - 1);
                check_psum($sformatf("psum %0d", got), exp_q.pop_front(), o_psum);
                check_last($sformatf("last of psum %0d", got), exp_last, o_psum_last);
                got++;
            end
        end
    endtask

    // Run limit of eight cycles per pixel slot plus margin
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("timeout: no progress within %0d cycles", cycle_limit));
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int sum_len;

        rst            = 1'b1;
        i_weight       = '0;
        i_weight_valid = 1'b0;
        i_pixel        = '0;
        i_pixel_valid  = 1'b0;
        i_line_len     = conv_line_pkg::pos_t'(3);
        i_psum_ready   = 1'b0;
        cur_test       = "reset";

        tests[0] = '{"min_line",       3,  1,  1'b0, 1'b0, 1'b0};
        tests[1] = '{"full_rate",      12, 10, 1'b0, 1'b0, 1'b0};
        tests[2] = '{"extremes",       9,  7,  1'b1, 1'b0, 1'b1};
        tests[3] = '{"pixel_gaps",     16, 14, 1'b1, 1'b0, 1'b0};
        tests[4] = '{"psum_stall",     20, 18, 1'b0, 1'b1, 1'b0};
        tests[5] = '{"gaps_and_stall", 33, 31, 1'b1, 1'b1, 1'b0};

        sum_len = 0;
        for (int t = 0; t < num_tests; t++) begin
            sum_len = sum_len + tests[t].len + 3;
        end
        cycle_limit = 8 * sum_len + 100;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_last("psum_valid after reset", 1'b0, o_psum_valid);
        check_last("pixel_ready after reset", 1'b0, o_pixel_ready);
        check_last("weight_ready after reset", 1'b1, o_weight_ready);

        for (int t = 0; t < num_tests; t++) begin
            cur_test = tests[t].name;
            prepare_line(tests[t]);
            @(posedge clk);
            i_line_len <= conv_line_pkg::pos_t'(tests[t].len);
            fork
                begin
                    load_weights();
                    drive_pixels(tests[t].len);
                end
                collect_psums(tests[t].n_psum, tests[t].rnd_ready);
            join
            // Weight buffer is back to filling once the last psum is taken
            @(negedge clk);
            check_last("psum_valid after line", 1'b0, o_psum_valid);
            check_last("weight_ready after line", 1'b1, o_weight_ready);
        end

        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected psums never arrived", exp_q.size()));
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/conv_line_engine_props.sv
`default_nettype none
`timescale 1ns/1ps

module conv_line_engine_props (
    input wire                           clk,
    input wire                           rst,
    input wire conv_line_pkg::psum_vec_t i_psum,
    input wire                           i_psum_valid,
    input wire                           i_psum_last,
    input wire                           i_psum_ready,
    input wire                           i_pixel_ready,
    input wire                           i_weight_ready
);

    // Stalled output holds value and last flag
    psum_hold_a: assert property (@(posedge clk) disable iff (rst)
        (i_psum_valid && !i_psum_ready) |=>
            (i_psum_valid && $stable(i_psum) && $stable(i_psum_last)))
        else $error("psum output changed while stalled");

    psum_last_valid_a: assert property (@(posedge clk) disable iff (rst)
        i_psum_last |-> i_psum_valid)
        else $error("psum last high without valid");

    // Pixels only flow while the weights are held
    ready_exclusive_a: assert property (@(posedge clk) disable iff (rst)
        !(i_pixel_ready && i_weight_ready))
        else $error("pixel ready and weight ready high together");

endmodule

bind conv_line_engine conv_line_engine_props i_conv_line_engine_props (
    .clk            (clk),
    .rst            (rst),
    .i_psum         (o_psum),
    .i_psum_valid   (o_psum_valid),
    .i_psum_last    (o_psum_last),
    .i_psum_ready   (i_psum_ready),
    .i_pixel_ready  (o_pixel_ready),
    .i_weight_ready (o_weight_ready)
);

`default_nettype wire

// File: source/conv_line_engine.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_line_config.svh"

module conv_line_engine (
    input  wire                              clk,
    input  wire                              rst,
    input  wire conv_line_pkg::weight_beat_t i_weight,
    input  wire                              i_weight_valid,
    output logic                             o_weight_ready,
    input  wire conv_line_pkg::pixel_t       i_pixel,
    input  wire                              i_pixel_valid,
    output logic                             o_pixel_ready,
    input  wire conv_line_pkg::pos_t         i_line_len,
    output conv_line_pkg::psum_vec_t         o_psum,
    output logic                             o_psum_valid,
    output logic                             o_psum_last,
    input  wire                              i_psum_ready
);

    // Weight path
    conv_line_pkg::weight_line_t weights;
    logic                        weights_loaded;
    logic                        line_done;

    // Window stream
    conv_line_pkg::window_t      window;
    logic                        window_valid;
    logic                        window_last;
    logic                        window_ready;

    // Channel sum stream
    conv_line_pkg::chsum_array_t chsum;
    logic                        chsum_valid;
    logic                        chsum_last;
    logic                        chsum_ready;

    weight_buffer u_weight_buffer (
        .clk              (clk),
        .rst              (rst),
        .i_weight         (i_weight),
        .i_weight_valid   (i_weight_valid),
        .o_weight_ready   (o_weight_ready),
        .i_line_done      (line_done),
        .o_weights        (weights),
        .o_weights_loaded (weights_loaded)
    );

    line_window_buffer u_line_window_buffer (
        .clk              (clk),
        .rst              (rst),
        .i_pixel          (i_pixel),
        .i_pixel_valid    (i_pixel_valid),
        .o_pixel_ready    (o_pixel_ready),
        .i_line_len       (i_line_len),
        .i_weights_loaded (weights_loaded),
        .o_window         (window),
        .o_window_valid   (window_valid),
        .o_window_last    (window_last),
        .i_window_ready   (window_ready)
    );

    kcpe_array u_kcpe_array (
        .clk            (clk),
        .rst            (rst),
        .i_window       (window),
        .i_window_valid (window_valid),
        .i_window_last  (window_last),
        .o_window_ready (window_ready),
        .i_weights      (weights),
        .o_chsum        (chsum),
        .o_chsum_valid  (chsum_valid),
        .o_chsum_last   (chsum_last),
        .i_chsum_ready  (chsum_ready)
    );

    psum_reducer u_psum_reducer (
        .clk           (clk),
        .rst           (rst),
        .i_chsum       (chsum),
        .i_chsum_valid (chsum_valid),
        .i_chsum_last  (chsum_last),
        .o_chsum_ready (chsum_ready),
        .o_psum        (o_psum),
        .o_psum_valid  (o_psum_valid),
        .o_psum_last   (o_psum_last),
        .i_psum_ready  (i_psum_ready),
        .o_line_done   (line_done)
    );

endmodule

`default_nettype wire

// File: source/psum_reducer.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_line_config.svh"

module psum_reducer (
    input  wire                              clk,
    input  wire                              rst,
    input  wire conv_line_pkg::chsum_array_t i_chsum,
    input  wire                              i_chsum_valid,
    input  wire                              i_chsum_last,
    output logic                             o_chsum_ready,
    output conv_line_pkg::psum_vec_t         o_psum,
    output logic                             o_psum_valid,
    output logic                             o_psum_last,
    input  wire                              i_psum_ready,
    output logic                             o_line_done
);

    conv_line_pkg::psum_vec_t psum_next;
    logic                     chsum_xfer;

    assign o_chsum_ready = ~o_psum_valid | i_psum_ready;
    assign chsum_xfer    = i_chsum_valid & o_chsum_ready;
    assign o_line_done   = o_psum_valid & o_psum_last & i_psum_ready;

    // Sum the three positions per kernel, sign extended
    always_comb begin
        logic signed [`CONV_PSUM_WIDTH-1:0] acc;

        for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
            acc = '0;
            for (int p = 0; p < `CONV_KERNEL_WIDTH; p++) begin
                acc = acc + $signed(i_chsum[(p*`CONV_NUM_KERNEL + k)*`CONV_CHSUM_WIDTH +:
                                            `CONV_CHSUM_WIDTH]);
            end
            psum_next[k*`CONV_PSUM_WIDTH +: `CONV_PSUM_WIDTH] = acc;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum_valid <= 1'b0;
            o_psum_last  <= 1'b0;
        end else if (chsum_xfer) begin
            o_psum_valid <= 1'b1;
            o_psum_last  <= i_chsum_last;
        end else if (i_psum_ready) begin
            o_psum_valid <= 1'b0;
            o_psum_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (chsum_xfer) begin
            o_psum <= psum_next;
        end
    end

endmodule

`default_nettype wire

// File: kcpe_array/kcpe_array.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_line_config.svh"

module kcpe_array (
    input  wire                              clk,
    input  wire                              rst,
    input  wire conv_line_pkg::window_t      i_window,
    input  wire                              i_window_valid,
    input  wire                              i_window_last,
    output logic                             o_window_ready,
    input  wire conv_line_pkg::weight_line_t i_weights,
    output conv_line_pkg::chsum_array_t      o_chsum,
    output logic                             o_chsum_valid,
    output logic                             o_chsum_last,
    input  wire                              i_chsum_ready
);

    conv_line_pkg::chsum_array_t chsum_next;
    logic                        window_xfer;

    assign o_window_ready = ~o_chsum_valid | i_chsum_ready;
    assign window_xfer    = i_window_valid & o_window_ready;

    ////////////////////////////////////////////////////////////
    // One PE per window position

    for (genvar p = 0; p < `CONV_KERNEL_WIDTH; p++) begin : g_pe
        kernel_channel_pe u_pe (
            .i_pixel  (i_window[p*$bits(conv_line_pkg::pixel_t) +:
                                $bits(conv_line_pkg::pixel_t)]),
            .i_weight (i_weights[p*$bits(conv_line_pkg::weight_beat_t) +:
                                 $bits(conv_line_pkg::weight_beat_t)]),
            .o_chsum  (chsum_next[p*$bits(conv_line_pkg::chsum_vec_t) +:
                                  $bits(conv_line_pkg::chsum_vec_t)])
        );
    end

    ////////////////////////////////////////////////////////////
    // Pipeline register

    always_ff @(posedge clk) begin
        if (rst) begin
            o_chsum_valid <= 1'b0;
            o_chsum_last  <= 1'b0;
        end else if (window_xfer) begin
            o_chsum_valid <= 1'b1;
            o_chsum_last  <= i_window_last;
        end else if (i_chsum_ready) begin
            o_chsum_valid <= 1'b0;
            o_chsum_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (window_xfer) begin
            o_chsum <= chsum_next;
        end
    end

endmodule

`default_nettype wire

// File: kcpe_array/kernel_channel_pe.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_line_config.svh"

module kernel_channel_pe (
    input  wire  [`CONV_NUM_CHANNEL*`CONV_DATA_WIDTH-1:0]                  i_pixel,
    input  wire  [`CONV_NUM_KERNEL*`CONV_NUM_CHANNEL*`CONV_DATA_WIDTH-1:0] i_weight,
    output logic [`CONV_NUM_KERNEL*`CONV_CHSUM_WIDTH-1:0]                  o_chsum
);

    // Signed dot product over channels, one per kernel
    always_comb begin
        logic signed [2*`CONV_DATA_WIDTH-1:0] prod;
        logic signed [`CONV_CHSUM_WIDTH-1:0]  acc;

        prod = '0;
        for (int k = 0; k < `CONV_NUM_KERNEL; k++) begin
            acc = '0;
            for (int c = 0; c < `CONV_NUM_CHANNEL; c++) begin
                prod = $signed(i_pixel[c*`CONV_DATA_WIDTH +: `CONV_DATA_WIDTH]) *
                       $signed(i_weight[(k*`CONV_NUM_CHANNEL + c)*`CONV_DATA_WIDTH +:
                                        `CONV_DATA_WIDTH]);
                acc  = acc + prod;
            end
            o_chsum[k*`CONV_CHSUM_WIDTH +: `CONV_CHSUM_WIDTH] = acc;
        end
    end

endmodule

`default_nettype wire

// File: source/line_window_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_line_config.svh"

module line_window_buffer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire conv_line_pkg::pixel_t i_pixel,
    input  wire                        i_pixel_valid,
    output logic                       o_pixel_ready,
    input  wire conv_line_pkg::pos_t   i_line_len,
    input  wire                        i_weights_loaded,
    output conv_line_pkg::window_t     o_window,
    output logic                       o_window_valid,
    output logic                       o_window_last,
    input  wire                        i_window_ready
);

    conv_line_pkg::pos_t line_idx;
    logic                line_end;
    logic                pixel_xfer;
    logic                idx_is_last;
    logic                idx_has_window;

    // Blocks the next line until the weights are reloaded
    assign o_pixel_ready  = i_weights_loaded & ~line_end &
                            (~o_window_valid | i_window_ready);
    assign pixel_xfer     = i_pixel_valid & o_pixel_ready;
    assign idx_is_last    = (line_idx == i_line_len - conv_line_pkg::pos_t'(1));
    assign idx_has_window = (line_idx >= conv_line_pkg::pos_t'(`CONV_KERNEL_WIDTH - 1));

    ////////////////////////////////////////////////////////////
    // Line position and window valid

    always_ff @(posedge clk) begin
        if (rst) begin
            line_idx       <= '0;
            line_end       <= 1'b0;
            o_window_valid <= 1'b0;
            o_window_last  <= 1'b0;
        end else begin
            if (pixel_xfer) begin
                o_window_valid <= idx_has_window;
                o_window_last  <= idx_has_window & idx_is_last;
                if (idx_is_last) begin
                    line_idx <= '0;
                    line_end <= 1'b1;
                end else begin
                    line_idx <= line_idx + conv_line_pkg::pos_t'(1);
                end
            end else if (i_window_ready) begin
                o_window_valid <= 1'b0;
                o_window_last  <= 1'b0;
            end

            // Weight buffer back in fill, so the line is fully drained
            if (!i_weights_loaded) begin
                line_end <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Pixel shift register, doubles as the window register

    // Newest pixel enters at position 2
    always_ff @(posedge clk) begin
        if (pixel_xfer) begin
            o_window <= {i_pixel,
                         o_window[$bits(conv_line_pkg::window_t)-1:
                                  $bits(conv_line_pkg::pixel_t)]};
        end
    end

endmodule

`default_nettype wire

// File: source/weight_buffer.sv
`default_nettype none
`timescale 1ns/1ps

`include "conv_line_config.svh"

module weight_buffer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire conv_line_pkg::weight_beat_t i_weight,
    input  wire                          i_weight_valid,
    output logic                         o_weight_ready,
    input  wire                          i_line_done,
    output conv_line_pkg::weight_line_t  o_weights,
    output logic                         o_weights_loaded
);

    conv_line_pkg::wbuf_state_t state;
    logic [1:0]                 beat_cnt;
    logic                       beat_xfer;

    assign o_weight_ready   = (state == conv_line_pkg::WBUF_FILL);
    assign o_weights_loaded = (state == conv_line_pkg::WBUF_HOLD);
    assign beat_xfer        = i_weight_valid & o_weight_ready;

    ////////////////////////////////////////////////////////////
    // Fill and hold control

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= conv_line_pkg::WBUF_FILL;
            beat_cnt <= 2'd0;
        end else begin
            case (state)
                conv_line_pkg::WBUF_FILL: begin
                    if (beat_xfer) begin
                        if (beat_cnt == 2'(`CONV_KERNEL_WIDTH - 1)) begin
                            state    <= conv_line_pkg::WBUF_HOLD;
                            beat_cnt <= 2'd0;
                        end else begin
                            beat_cnt <= beat_cnt + 2'd1;
                        end
                    end
                end
                default: begin
                    // Refill once the line's last psum has left
                    if (i_line_done) begin
                        state <= conv_line_pkg::WBUF_FILL;
                    end
                end
            endcase
        end
    end

    // Beat n lands in position slot n
    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            o_weights[beat_cnt*$bits(conv_line_pkg::weight_beat_t) +:
                      $bits(conv_line_pkg::weight_beat_t)] <= i_weight;
        end
    end

endmodule

`default_nettype wire

// File: common/conv_line_pkg.sv
`default_nettype none

`include "conv_line_config.svh"

package conv_line_pkg;

    typedef logic [`CONV_DATA_WIDTH-1:0] data_t;
    typedef logic [`CONV_NUM_CHANNEL*`CONV_DATA_WIDTH-1:0] pixel_t;
    typedef logic [`CONV_POS_WIDTH-1:0] pos_t;

    // Position 0 is the oldest pixel, in the low bits
    typedef logic [`CONV_KERNEL_WIDTH*`CONV_NUM_CHANNEL*`CONV_DATA_WIDTH-1:0] window_t;

    // One kernel position, kernel 0 in the low bits
    typedef logic [`CONV_NUM_KERNEL*`CONV_NUM_CHANNEL*`CONV_DATA_WIDTH-1:0] weight_beat_t;
    typedef logic [`CONV_KERNEL_WIDTH*$bits(weight_beat_t)-1:0] weight_line_t;

    typedef logic [`CONV_NUM_KERNEL*`CONV_CHSUM_WIDTH-1:0] chsum_vec_t;
    typedef logic [`CONV_KERNEL_WIDTH*$bits(chsum_vec_t)-1:0] chsum_array_t;

    typedef logic [`CONV_PSUM_WIDTH-1:0] psum_t;
    typedef logic [`CONV_NUM_KERNEL*`CONV_PSUM_WIDTH-1:0] psum_vec_t;

    typedef enum logic {WBUF_FILL, WBUF_HOLD} wbuf_state_t;

endpackage

`default_nettype wire

// File: common/conv_line_config.svh
`ifndef CONV_LINE_CONFIG_SVH
`define CONV_LINE_CONFIG_SVH

// Element width of pixels and weights, signed
`define CONV_DATA_WIDTH 8

// Channels per pixel and kernels in parallel
`define CONV_NUM_CHANNEL 3
`define CONV_NUM_KERNEL 4

// Window width, also the PE count
`define CONV_KERNEL_WIDTH 3

`define CONV_POS_WIDTH 8

// 3 products of 16 bits, then 3 positions on top
`define CONV_CHSUM_WIDTH 18
`define CONV_PSUM_WIDTH 20

`endif
